// File: design/uno_disp_pkg.sv
package uno_disp_pkg;

    localparam int COORD_W = 10;
    localparam int INDEX_W = 7;

    // 640x480 at 60 Hz on a 25 MHz pixel clock.
    localparam logic [COORD_W-1:0] H_TOTAL     = 10'd800;
    localparam logic [COORD_W-1:0] V_TOTAL     = 10'd525;
    localparam logic [COORD_W-1:0] H_SYNC      = 10'd96;  // sync low from count 0.
    localparam logic [COORD_W-1:0] V_SYNC      = 10'd2;
    localparam logic [COORD_W-1:0] H_ACT_START = 10'd144;
    localparam logic [COORD_W-1:0] H_ACT_END   = 10'd784;
    localparam logic [COORD_W-1:0] V_ACT_START = 10'd35;
    localparam logic [COORD_W-1:0] V_ACT_END   = 10'd515;

    localparam logic [INDEX_W-1:0] HAND_SLOTS = 7'd109;
    localparam logic [INDEX_W-1:0] ROW_SLOTS  = 7'd15;
    localparam logic [INDEX_W-1:0] BASE_MAX   = 7'd94;  // HAND_SLOTS - ROW_SLOTS.

    // table layout in raw counter coordinates.
    localparam logic [COORD_W-1:0] ROW_X0     = 10'd170;
    localparam logic [COORD_W-1:0] SLOT_PITCH = 10'd40;
    localparam logic [COORD_W-1:0] CARD_W     = 10'd30;
    localparam logic [COORD_W-1:0] ROW_X1     = 10'd770;  // ROW_X0 + 15 pitches.
    localparam logic [COORD_W-1:0] ROW_Y0     = 10'd420;
    localparam logic [COORD_W-1:0] CARD_H     = 10'd50;
    localparam logic [COORD_W-1:0] MARK_Y0    = 10'd470;
    localparam logic [COORD_W-1:0] MARK_H     = 10'd10;
    localparam logic [COORD_W-1:0] PREV_X0    = 10'd430;
    localparam logic [COORD_W-1:0] PREV_Y0    = 10'd230;
    localparam logic [COORD_W-1:0] PANEL_X0   = 10'd160;
    localparam logic [COORD_W-1:0] PANEL_X1   = 10'd760;
    localparam logic [COORD_W-1:0] PANEL_Y0   = 10'd50;
    localparam logic [COORD_W-1:0] PANEL_Y1   = 10'd480;

    localparam logic [3:0] KIND_WILD  = 4'd13;
    localparam logic [3:0] KIND_WILD4 = 4'd14;
    localparam logic [3:0] KIND_EMPTY = 4'd15;

    // colour 0 red, 1 yellow, 2 green, 3 blue.
    typedef struct packed {
        logic [1:0] colour;
        logic [3:0] kind;
    } card_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // element 0 is the rightmost word.
    localparam logic [3:0][23:0] PAL_CARD = {
        24'h2040FF,
        24'h20B040,
        24'hFFD020,
        24'hFF2020
    };
    localparam rgb_t PAL_WILD    = 24'h101010;
    localparam rgb_t PAL_BORDER  = 24'h000000;
    localparam rgb_t PAL_PANEL   = 24'h206020;
    localparam rgb_t PAL_OUTSIDE = 24'h000000;
    localparam rgb_t PAL_MARK    = 24'hFFFFFF;

endpackage

// File: design/scan_if.sv
`timescale 1ns/1ps

interface scan_if;
    import uno_disp_pkg::*;

    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
    logic               hs;      // active low.
    logic               vs;      // active low.
    logic               active;

    modport source (
        output x, y, hs, vs, active
    );

    modport sink (
        input x, y, hs, vs, active
    );

endinterface

// File: design/vga_timing.sv
`timescale 1ns/1ps

module vga_timing (
    input  logic   i_clk_25M,
    input  logic   i_rst_n,
    scan_if.source o_scan
);
    import uno_disp_pkg::*;

    logic [COORD_W-1:0] x_cnt;
    logic [COORD_W-1:0] y_cnt;
    logic               x_wrap;
    logic               y_wrap;

    assign x_wrap = (x_cnt == H_TOTAL - 1'b1);
    assign y_wrap = (y_cnt == V_TOTAL - 1'b1);

    always_ff @(posedge i_clk_25M or negedge i_rst_n) begin
        if (!i_rst_n) begin
            x_cnt <= '0;
        end else if (x_wrap) begin
            x_cnt <= '0;
        end else begin
            x_cnt <= x_cnt + 1'b1;
        end
    end

    // lines advance on the last pixel of each line.
    always_ff @(posedge i_clk_25M or negedge i_rst_n) begin
        if (!i_rst_n) begin
            y_cnt <= '0;
        end else if (x_wrap) begin
            if (y_wrap) begin
                y_cnt <= '0;
            end else begin
                y_cnt <= y_cnt + 1'b1;
            end
        end
    end

    assign o_scan.x  = x_cnt;
    assign o_scan.y  = y_cnt;
    assign o_scan.hs = (x_cnt >= H_SYNC);  // low during the first 96 clocks.
    assign o_scan.vs = (y_cnt >= V_SYNC);

    assign o_scan.active = (x_cnt >= H_ACT_START) && (x_cnt < H_ACT_END) &&
                           (y_cnt >= V_ACT_START) && (y_cnt < V_ACT_END);

endmodule

// File: design/hand_window.sv
`timescale 1ns/1ps

module hand_window (
    input  logic                                i_clk_25M,
    input  logic                                i_rst_n,
    input  logic [uno_disp_pkg::INDEX_W-1:0]    i_index,
    input  uno_disp_pkg::card_t                 i_hands [uno_disp_pkg::HAND_SLOTS-1:0],
    scan_if.sink                                i_scan,
    output uno_disp_pkg::card_t                 o_slot_card,
    output logic                                o_slot_is_cursor,
    output logic [uno_disp_pkg::INDEX_W-1:0]    o_window_base
);
    import uno_disp_pkg::*;

    logic [INDEX_W-1:0] base_r;
    logic [COORD_W-1:0] x_off;
    logic [COORD_W-1:0] slot;
    logic [COORD_W-1:0] entry;
    logic               entry_ok;

    // one step per clock toward keeping the cursor in view.
    always_ff @(posedge i_clk_25M or negedge i_rst_n) begin
        if (!i_rst_n) begin
            base_r <= '0;
        end else if ((i_index > base_r + (ROW_SLOTS - 1'b1)) && (base_r < BASE_MAX)) begin
            base_r <= base_r + 1'b1;
        end else if ((i_index < base_r) && (base_r != '0)) begin
            base_r <= base_r - 1'b1;
        end
    end

    assign x_off = i_scan.x - ROW_X0;
    assign slot  = x_off / SLOT_PITCH;
    assign entry = COORD_W'(base_r) + slot;

    // base never passes BASE_MAX, so every visible slot maps inside the hand store.
    assign entry_ok = (i_scan.x >= ROW_X0) && (slot < COORD_W'(ROW_SLOTS));

    always_comb begin
        o_slot_card      = '{colour: 2'd0, kind: KIND_EMPTY};
        o_slot_is_cursor = 1'b0;
        if (entry_ok) begin
            o_slot_card      = i_hands[entry[INDEX_W-1:0]];
            o_slot_is_cursor = (entry[INDEX_W-1:0] == i_index);
        end
    end

    assign o_window_base = base_r;

endmodule

// File: design/card_painter.sv
`timescale 1ns/1ps

module card_painter (
    input  logic                i_clk_25M,
    input  logic                i_rst_n,
    scan_if.sink                i_scan,
    input  uno_disp_pkg::card_t i_slot_card,
    input  logic                i_slot_is_cursor,
    input  uno_disp_pkg::card_t i_prev_card,
    output uno_disp_pkg::rgb_t  o_rgb,
    output logic                o_hs,
    output logic                o_vs,
    output logic                o_blank_n
);
    import uno_disp_pkg::*;

    logic [COORD_W-1:0] x_off;
    logic [COORD_W-1:0] col;
    logic               in_slot_col;
    logic               in_prev;
    logic               prev_edge;
    logic               in_hand;
    logic               hand_edge;
    logic               in_mark;
    logic               in_panel;
    rgb_t               pix;

    // empty slots show the panel, wilds are flat black.
    function automatic rgb_t card_fill(input card_t card, input logic edge_px);
        rgb_t fill;
        if (card.kind == KIND_EMPTY) begin
            fill = PAL_PANEL;
        end else if (edge_px) begin
            fill = PAL_BORDER;
        end else if ((card.kind == KIND_WILD) || (card.kind == KIND_WILD4)) begin
            fill = PAL_WILD;
        end else begin
            fill = rgb_t'(PAL_CARD[card.colour]);
        end
        return fill;
    endfunction

    assign x_off       = i_scan.x - ROW_X0;
    assign col         = x_off % SLOT_PITCH;  // column inside the slot pitch.
    assign in_slot_col = (i_scan.x >= ROW_X0) && (i_scan.x < ROW_X1) && (col < CARD_W);

    assign in_prev   = (i_scan.x >= PREV_X0) && (i_scan.x < PREV_X0 + CARD_W) &&
                       (i_scan.y >= PREV_Y0) && (i_scan.y < PREV_Y0 + CARD_H);
    assign prev_edge = (i_scan.x == PREV_X0) || (i_scan.x == PREV_X0 + CARD_W - 1'b1) ||
                       (i_scan.y == PREV_Y0) || (i_scan.y == PREV_Y0 + CARD_H - 1'b1);

    assign in_hand   = in_slot_col && (i_scan.y >= ROW_Y0) && (i_scan.y < ROW_Y0 + CARD_H);
    assign hand_edge = (col == '0) || (col == CARD_W - 1'b1) ||
                       (i_scan.y == ROW_Y0) || (i_scan.y == ROW_Y0 + CARD_H - 1'b1);

    assign in_mark  = (i_scan.y >= MARK_Y0) && (i_scan.y < MARK_Y0 + MARK_H);
    assign in_panel = (i_scan.x >= PANEL_X0) && (i_scan.x < PANEL_X1) &&
                      (i_scan.y >= PANEL_Y0) && (i_scan.y < PANEL_Y1);

    // regions in priority order.
    always_comb begin
        pix = PAL_OUTSIDE;
        if (!i_scan.active) begin
            pix = '0;
        end else if (in_prev) begin
            pix = card_fill(i_prev_card, prev_edge);
        end else if (in_hand) begin
            pix = card_fill(i_slot_card, hand_edge);
        end else if (in_mark) begin
            pix = (in_slot_col && i_slot_is_cursor) ? PAL_MARK : PAL_PANEL;
        end else if (in_panel) begin
            pix = PAL_PANEL;
        end
    end

    // syncs go through the same stage as the pixel.
    always_ff @(posedge i_clk_25M or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rgb     <= '0;
            o_hs      <= 1'b1;
            o_vs      <= 1'b1;
            o_blank_n <= 1'b0;
        end else begin
            o_rgb     <= pix;
            o_hs      <= i_scan.hs;
            o_vs      <= i_scan.vs;
            o_blank_n <= i_scan.active;
        end
    end

endmodule

// File: design/uno_display_top.sv
`timescale 1ns/1ps

module uno_display_top (
    input  logic                             i_clk_25M,
    input  logic                             i_rst_n,
    input  logic [5:0]                       i_hands [uno_disp_pkg::HAND_SLOTS-1:0],
    input  logic [uno_disp_pkg::INDEX_W-1:0] i_index,
    input  logic [5:0]                       i_prev_card,
    output logic [7:0]                       o_vga_r,
    output logic [7:0]                       o_vga_g,
    output logic [7:0]                       o_vga_b,
    output logic                             o_vga_hs,
    output logic                             o_vga_vs,
    output logic                             o_vga_blank_n,
    output logic                             o_vga_clk,
    output logic [uno_disp_pkg::INDEX_W-1:0] o_window_base
);
    import uno_disp_pkg::*;

    card_t hands [HAND_SLOTS-1:0];
    card_t prev_card;
    card_t slot_card;
    logic  slot_is_cursor;
    rgb_t  rgb;

    scan_if scan ();

    for (genvar k = 0; k < HAND_SLOTS; k++) begin : gen_hand
        assign hands[k] = card_t'(i_hands[k]);
    end

    assign prev_card = card_t'(i_prev_card);

    vga_timing u_timing (
        .i_clk_25M (i_clk_25M),
        .i_rst_n   (i_rst_n),
        .o_scan    (scan.source)
    );

    hand_window u_window (
        .i_clk_25M        (i_clk_25M),
        .i_rst_n          (i_rst_n),
        .i_index          (i_index),
        .i_hands          (hands),
        .i_scan           (scan.sink),
        .o_slot_card      (slot_card),
        .o_slot_is_cursor (slot_is_cursor),
        .o_window_base    (o_window_base)
    );

    card_painter u_painter (
        .i_clk_25M        (i_clk_25M),
        .i_rst_n          (i_rst_n),
        .i_scan           (scan.sink),
        .i_slot_card      (slot_card),
        .i_slot_is_cursor (slot_is_cursor),
        .i_prev_card      (prev_card),
        .o_rgb            (rgb),
        .o_hs             (o_vga_hs),
        .o_vs             (o_vga_vs),
        .o_blank_n        (o_vga_blank_n)
    );

    assign o_vga_r   = rgb.r;
    assign o_vga_g   = rgb.g;
    assign o_vga_b   = rgb.b;
    assign o_vga_clk = ~i_clk_25M;  // DAC latches on the falling pixel edge.

endmodule

// File: bench/uno_display_props.sv
`timescale 1ns/1ps

module uno_display_props (
    input logic                             i_clk_25M,
    input logic                             i_rst_n,
    input logic                             i_hs,
    input logic                             i_vs,
    input logic [uno_disp_pkg::INDEX_W-1:0] i_window_base
);

    int hs_run;  // clocks of the current low run.
    int vs_run;
    int fail_count = 0;

    always_ff @(posedge i_clk_25M or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hs_run <= 0;
            vs_run <= 0;
        end else begin
            hs_run <= i_hs ? 0 : hs_run + 1;
            vs_run <= i_vs ? 0 : vs_run + 1;
        end
    end

    a_hs_width: assert property (@(posedge i_clk_25M) disable iff (!i_rst_n)
        $rose(i_hs) |-> (hs_run == 96))
        else begin
            $error("hs pulse is not 96 clocks wide");
            fail_count++;
        end

    // two lines of 800 clocks.
    a_vs_width: assert property (@(posedge i_clk_25M) disable iff (!i_rst_n)
        $rose(i_vs) |-> (vs_run == 1600))
        else begin
            $error("vs pulse is not two lines wide");
            fail_count++;
        end

    a_base_max: assert property (@(posedge i_clk_25M) disable iff (!i_rst_n)
        i_window_base <= 7'd94)
        else begin
            $error("window base above 94");
            fail_count++;
        end

endmodule

// File: bench/tb_uno_display.sv
`timescale 1ns/1ps

module tb_uno_display;

    localparam int CLK_PERIOD  = 40;
    localparam int LINE_CLKS   = 800;
    localparam int FRAME_LINES = 525;
    localparam int TIMEOUT     = 2 * LINE_CLKS * FRAME_LINES;  // two frames.
    localparam int BASE_STEPS  = 94;
    localparam int N_HAND      = 109;
    localparam int N_REC       = 14;

    logic        i_clk_25M;
    logic        i_rst_n;
    logic [5:0]  i_hands [108:0];
    logic [6:0]  i_index;
    logic [5:0]  i_prev_card;
    logic [7:0]  o_vga_r;
    logic [7:0]  o_vga_g;
    logic [7:0]  o_vga_b;
    logic        o_vga_hs;
    logic        o_vga_vs;
    logic        o_vga_blank_n;
    logic        o_vga_clk;
    logic [6:0]  o_window_base;

    logic [23:0] tdata [0:N_HAND+6*N_REC-1];  // hand words, then six words per record.
    int          ref_x;
    int          ref_y;
    int          errors;
    int          tests;
    int          passed;
    bit          timed_out;

    uno_display_top DUT (.*);

    bind uno_display_top uno_display_props u_props (
        .i_clk_25M     (i_clk_25M),
        .i_rst_n       (i_rst_n),
        .i_hs          (o_vga_hs),
        .i_vs          (o_vga_vs),
        .i_window_base (o_window_base)
    );

    initial begin
        i_clk_25M = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) i_clk_25M = ~i_clk_25M;
        end
    end

    // scan position held by the DUT counters.
    always @(posedge i_clk_25M or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ref_x <= 0;
            ref_y <= 0;
        end else if (ref_x == LINE_CLKS - 1) begin
            ref_x <= 0;
            ref_y <= (ref_y == FRAME_LINES - 1) ? 0 : ref_y + 1;
        end else begin
            ref_x <= ref_x + 1;
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic log_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: FAILED", name);
        end
    endtask

    function automatic logic sync_level(input bit vert);
        return vert ? o_vga_vs : o_vga_hs;
    endfunction

    // counts falling edges until the sync reaches lvl.
    task automatic wait_sync(input bit vert, input logic lvl, output int n);
        n = 0;
        while (sync_level(vert) !== lvl && !timed_out) begin
            @(negedge i_clk_25M);
            n++;
            if (n >= TIMEOUT) begin
                $display("timeout: %s sync never went to %b",
                         vert ? "vertical" : "horizontal", lvl);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_base(input logic [6:0] exp, output int n);
        n = 0;
        while (o_window_base !== exp && !timed_out) begin
            @(negedge i_clk_25M);
            n++;
            if (n >= TIMEOUT) begin
                $display("timeout: window base never reached %0d", exp);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_probe(input int px, input int py);
        int n;
        n = 0;
        while (!(ref_x == px && ref_y == py) && !timed_out) begin
            @(negedge i_clk_25M);
            n++;
            if (n >= TIMEOUT) begin
                $display("timeout: scan never reached x %0d y %0d", px, py);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic sync_test(input bit vert, input int exp_low, input int exp_period);
        int n;
        int low_n;
        int high_n;
        int err_before;
        err_before = errors;
        wait_sync(vert, 1'b1, n);
        wait_sync(vert, 1'b0, n);  // now at the first clock of a pulse.
        wait_sync(vert, 1'b1, low_n);
        wait_sync(vert, 1'b0, high_n);
        if (timed_out) return;
        check(32'(low_n), 32'(exp_low), vert ? "vs low clocks" : "hs low clocks");
        check(32'(low_n + high_n), 32'(exp_period), vert ? "vs period" : "hs period");
        log_test(vert ? "vs shape" : "hs shape", err_before);
    endtask

    // the DAC clock is high while the pixel clock is low.
    task automatic vga_clk_test();
        int err_before;
        err_before = errors;
        repeat (4) begin
            @(negedge i_clk_25M);
            #(CLK_PERIOD / 4);
            check(32'(o_vga_clk), 32'd1, "vga clock in the low pixel phase");
            @(posedge i_clk_25M);
            #(CLK_PERIOD / 4);
            check(32'(o_vga_clk), 32'd0, "vga clock in the high pixel phase");
        end
        @(negedge i_clk_25M);
        log_test("vga clock", err_before);
    endtask

    task automatic probe_test(input int r);
        int   b;
        int   px;
        int   py;
        int   n;
        int   err_before;
        logic vis;
        b          = N_HAND + 6 * r;
        px         = int'(tdata[b+2]);
        py         = int'(tdata[b+3]);
        err_before = errors;
        i_index     = tdata[b][6:0];
        i_prev_card = tdata[b+1][5:0];
        wait_base(tdata[b+4][6:0], n);
        if (timed_out) return;
        check(32'(n <= BASE_STEPS), 32'd1, "window base settled within 94 clocks");
        wait_probe(px, py);
        if (timed_out) return;
        @(negedge i_clk_25M);  // pixel latency of one clock.
        vis = (px >= 144) && (px < 784) && (py >= 35) && (py < 515);
        check(32'({o_vga_r, o_vga_g, o_vga_b}), 32'(tdata[b+5]),
              $sformatf("rgb at x %0d y %0d", px, py));
        check(32'(o_vga_blank_n), 32'(vis), $sformatf("blank_n at x %0d y %0d", px, py));
        check(32'(o_window_base), 32'(tdata[b+4]), "window base");
        log_test($sformatf("record %0d", r), err_before);
    endtask

    task automatic run_tests();
        sync_test(1'b0, 96, LINE_CLKS);
        if (timed_out) return;
        sync_test(1'b1, 2 * LINE_CLKS, LINE_CLKS * FRAME_LINES);
        if (timed_out) return;
        vga_clk_test();
        for (int r = 0; r < N_REC && !timed_out; r++) begin
            probe_test(r);
        end
    endtask

    initial begin
        errors      = 0;
        tests       = 0;
        passed      = 0;
        timed_out   = 1'b0;
        i_rst_n     = 1'b0;
        i_index     = '0;
        i_prev_card = '0;
        $readmemh("bench/uno_testdata.hex", tdata);
        for (int k = 0; k < N_HAND; k++) begin
            i_hands[k] = tdata[k][5:0];
        end
        repeat (2) @(negedge i_clk_25M);
        i_rst_n = 1'b1;
        run_tests();
        $display("%0d of %0d tests passed, %0d check errors, %0d assertion failures",
                 passed, tests, errors, DUT.u_props.fail_count);
        if (timed_out || errors != 0 || DUT.u_props.fail_count != 0) begin
            $display("RESULT: FAIL");
        end else begin
            $display("RESULT: PASS");
        end
        $finish;
    end

endmodule

// File: bench/uno_testdata.hex
// hand store: 109 card words, colour in bits 5:4, kind in bits 3:0
// records: cursor prev_card probe_x probe_y expected_base expected_rgb
00 11 22 33 04 15 26 37 08 19 20 31 02 13 24 35
06 17 28 39 00 11 22 33 04 15 26 37 0D 19 1E 31
02 2F 24 35 06 17 28 39 00 11 22 33 04 15 26 37
08 19 20 31 02 13 24 35 06 17 28 39 00 11 22 33
04 15 26 37 08 19 20 31 02 13 24 35 06 17 28 39
00 11 22 33 04 15 26 37 08 19 20 31 02 13 24 35
06 17 28 39 00 11 22 33 04 15 26 37 08
28 13 1BD 0FF 1A FFD020
28 2D 1BD 0FF 1A 101010
28 13 0AA 1BD 1A 000000
28 13 0B9 1BD 1A 20B040
28 13 109 1BD 1A 101010
28 13 159 1BD 1A 101010
28 13 1D1 1BD 1A 206020
28 13 0B9 1DB 1A 206020
28 13 2E9 1DB 1A FFFFFF
03 13 0B9 1BD 03 2040FF
6C 13 2E9 1BD 5E FF2020
00 13 12C 064 00 206020
00 13 064 064 00 000000
00 13 096 064 00 000000

// File: flist.f
design/uno_disp_pkg.sv
design/scan_if.sv
design/vga_timing.sv
design/hand_window.sv
design/card_painter.sv
design/uno_display_top.sv
bench/uno_display_props.sv
bench/tb_uno_display.sv

// File: Makefile
# Verilator build and run of the VGA display testbench.

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -f flist.f --top-module tb_uno_display -o sim_uno
	-./obj_dir/sim_uno +verilator+error+limit+100 > sim.log 2>&1
	@cat sim.log
	@grep -q "^RESULT: PASS$$" sim.log && echo "test passed" || (echo "test failed"; exit 1)

clean:
	rm -rf obj_dir sim.log
